// File: build.f
source/cpuPkg.sv
source/mainControl.sv
source/registerFile.sv
source/alu.sv
source/pcUnit.sv
source/dataMemory.sv
source/cpuCore.sv
dv/cpuCoreTb.sv

// File: dv/cpuCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

	localparam int halfPeriod = 20;
	localparam int minResetCycles = 4;
	localparam int driveDelay = 1;
	// Just before the next rising edge
	localparam int sampleDelay = 38;

	logic clk;
	logic rst;
	logic [15:0] instr;
	logic [15:0] instrAddr;
	logic halt;
	cpuPkg::retireT retire;

	// Raw words of the stimulus file
	logic [15:0] stimWords [0:511];
	logic [15:0] progMem [0:255];
	logic [15:0] progLen = '0;
	cpuPkg::retireT expectQ [$];
	int recCount = 0;
	int retired = 0;
	int cycleCount = 0;
	int cycleLimit = 0;
	logic [15:0] lastPc = '0;

	cpuCore u_dut (
		.clk(clk),
		.rst(rst),
		.instrAddr(instrAddr),
		.instr(instr),
		.halt(halt),
		.retire(retire)
	);

	always #halfPeriod clk = ~clk;

	// Instruction memory, fetches past the program see HLT
	assign instr = (instrAddr < progLen) ? progMem[instrAddr[7:0]] : 16'hf000;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic compareField(input string name, input logic [15:0] got,
		input logic [15:0] want);
		if (got !== want)
			abortRun($sformatf("[ERROR] %s after %0d retired: got 0x%h, expected 0x%h",
				name, retired, got, want));
	endtask

	task automatic loadStimulus();
		int pos;
		cpuPkg::retireT rec;
		$readmemh("dv/cpuStim.txt", stimWords);
		if ($isunknown(stimWords[0]) || stimWords[0] > 16'd256) begin
			abortRun("stimulus file is missing or holds a bad program length");
		end else begin
			progLen = stimWords[0];
			for (int i = 0; i < int'(progLen); i++)
				progMem[i] = stimWords[i + 1];
			pos = int'(progLen) + 1;
			recCount = int'(stimWords[pos]);
			pos++;
			// Seven words per record
			for (int r = 0; r < recCount; r++) begin
				rec.pc = stimWords[pos];
				rec.regWe = stimWords[pos + 1][0];
				rec.regAddr = stimWords[pos + 2][3:0];
				rec.regData = stimWords[pos + 3];
				rec.memWe = stimWords[pos + 4][0];
				rec.memAddr = stimWords[pos + 5][7:0];
				rec.memData = stimWords[pos + 6];
				expectQ.push_back(rec);
				pos += 7;
			end
			cycleLimit = 4 * recCount + 50;
		end
	endtask

	task automatic checkRetire();
		cpuPkg::retireT want;
		if (expectQ.size() == 0) begin
			abortRun($sformatf("core retired pc 0x%h with no expected record left",
				retire.pc));
		end else begin
			want = expectQ.pop_front();
			compareField("retire.pc", retire.pc, want.pc);
			compareField("retire.regWe", 16'(retire.regWe), 16'(want.regWe));
			compareField("retire.regAddr", 16'(retire.regAddr), 16'(want.regAddr));
			compareField("retire.regData", retire.regData, want.regData);
			compareField("retire.memWe", 16'(retire.memWe), 16'(want.memWe));
			compareField("retire.memAddr", 16'(retire.memAddr), 16'(want.memAddr));
			compareField("retire.memData", retire.memData, want.memData);
			lastPc = want.pc;
			retired++;
		end
	endtask

	// Run limit follows the number of expected records
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit)
			abortRun($sformatf("core did not halt within %0d cycles", cycleLimit));
	end

	initial begin
		int extraReset;
		clk = 1'b0;
		rst = 1'b1;
		void'($urandom(32'hfd1f_db4d));
		loadStimulus();
		// A few random reset cycles beyond the minimum
		extraReset = $urandom % 4;
		repeat (minResetCycles + extraReset) @(posedge clk);
		#driveDelay rst = 1'b0;

		#(sampleDelay - driveDelay);
		while (!halt) begin
			checkRetire();
			@(posedge clk);
			#sampleDelay;
		end

		// PC should sit on the HLT
		repeat (3) @(posedge clk);
		#sampleDelay;
		compareField("instrAddr", instrAddr, lastPc);
		compareField("halt", 16'(halt), 16'd1);
		if (expectQ.size() != 0) begin
			abortRun($sformatf("core halted with %0d expected records left",
				expectQ.size()));
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: dv/cpuStim.txt
// Program length, then the program words from address 0, eight per line
0032
A134 B112 A2FF B27F A301 0423 0513 A600
B680 1763 1811 C201 A9EE 2912 2A11 3B12
C201 A9EE C005 1C31 C601 A9EE C401 CC01
4D14 5E63 6F14 7921 7A6C 9135 9FBC 8C35
8DBC 8E37 A055 0903 E800 A829 DE80 A9EE
A9EE D280 C802 A9EE A9EE CA01 CE02 0111
F000 CFFD
// Expected record count, then records in retire order, two per line
// pc regWe regAddr regData memWe memAddr memData
002B
0000 1 1 0034 0 00 0000    0001 1 1 1234 0 00 0000
0002 1 2 00FF 0 00 0000    0003 1 2 7FFF 0 00 0000
0004 1 3 0001 0 00 0000    0005 1 4 7FFF 0 00 0000
0006 1 5 1235 0 00 0000    0007 1 6 0000 0 00 0000
0008 1 6 8000 0 00 0000    0009 1 7 8000 0 00 0000
000A 1 8 0000 0 00 0000    000B 0 0 0000 0 00 0000
000D 1 9 6DCB 0 00 0000    000E 1 A 0000 0 00 0000
000F 1 B 00C4 0 00 0000    0010 0 0 0000 0 00 0000
0012 0 0 0000 0 00 0000    0013 1 C EDCD 0 00 0000
0014 0 0 0000 0 00 0000    0016 0 0 0000 0 00 0000
0017 0 0 0000 0 00 0000    0018 1 D 2340 0 00 0000
0019 1 E F000 0 00 0000    001A 1 F 4123 0 00 0000
001B 1 9 7123 0 00 0000    001C 1 A 8DCD 0 00 0000
001D 0 0 0000 1 06 1234    001E 0 0 0000 1 C0 4123
001F 1 C 1234 0 00 0000    0020 1 D 4123 0 00 0000
0021 1 E 0000 0 00 0000    0022 1 0 0055 0 00 0000
0023 1 9 0001 0 00 0000    0024 1 8 0025 0 00 0000
0025 1 8 0029 0 00 0000    0026 0 0 0000 0 00 0000
0029 0 0 0000 0 00 0000    002A 0 0 0000 0 00 0000
002D 0 0 0000 0 00 0000    002E 0 0 0000 0 00 0000
0031 0 0 0000 0 00 0000    002F 1 1 2468 0 00 0000
0030 0 0 0000 0 00 0000

// File: run.sh
#!/bin/sh
# Builds and runs the cpuCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module cpuCoreTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VcpuCoreTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  cpuPkg::opcodeT                op,
	input  logic [cpuPkg::dataWidth-1:0]  a,
	input  logic [cpuPkg::dataWidth-1:0]  b,
	output logic [cpuPkg::dataWidth-1:0]  result,
	output cpuPkg::flagsT                 flags
);

	logic [cpuPkg::dataWidth-1:0] sum;
	logic [cpuPkg::dataWidth-1:0] diff;
	logic [cpuPkg::dataWidth-1:0] nibbleSum;
	logic [2*cpuPkg::dataWidth-1:0] rotated;
	logic [9:0] byteSum;
	logic addOvf;
	logic subOvf;
	logic overflow;

	// Largest magnitude of the given sign
	function automatic logic [cpuPkg::dataWidth-1:0] satWord(input logic neg);
		return {neg, {(cpuPkg::dataWidth-1){~neg}}};
	endfunction

	// One signed 4-bit lane, clamped to -8..7
	function automatic logic [3:0] addNibbleSat(input logic [3:0] x, input logic [3:0] y);
		logic [3:0] s;
		s = x + y;
		if ((x[3] == y[3]) && (s[3] != x[3])) begin
			return x[3] ? 4'h8 : 4'h7;
		end
		return s;
	endfunction

	assign sum = a + b;
	assign diff = a - b;
	assign addOvf = (a[cpuPkg::dataWidth-1] == b[cpuPkg::dataWidth-1]) &&
		(sum[cpuPkg::dataWidth-1] != a[cpuPkg::dataWidth-1]);
	assign subOvf = (a[cpuPkg::dataWidth-1] != b[cpuPkg::dataWidth-1]) &&
		(diff[cpuPkg::dataWidth-1] != a[cpuPkg::dataWidth-1]);

	// Signed sum of all four bytes
	assign byteSum = {{2{a[15]}}, a[15:8]} + {{2{a[7]}}, a[7:0]} +
		{{2{b[15]}}, b[15:8]} + {{2{b[7]}}, b[7:0]};

	assign rotated = {a, a} >> b[3:0];

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			nibbleSum[i*4 +: 4] = addNibbleSat(a[i*4 +: 4], b[i*4 +: 4]);
		end
	end

	always_comb begin
		// LW, SW and the rest use the plain sum
		result = sum;
		overflow = 1'b0;
		case (op)
			cpuPkg::ADD: begin
				result = addOvf ? satWord(a[cpuPkg::dataWidth-1]) : sum;
				overflow = addOvf;
			end
			cpuPkg::SUB: begin
				result = subOvf ? satWord(a[cpuPkg::dataWidth-1]) : diff;
				overflow = subOvf;
			end
			cpuPkg::XOR: result = a ^ b;
			cpuPkg::RED: result = {{6{byteSum[9]}}, byteSum};
			cpuPkg::SLL: result = a << b[3:0];
			cpuPkg::SRA: result = $unsigned($signed(a) >>> b[3:0]);
			cpuPkg::ROR: result = rotated[cpuPkg::dataWidth-1:0];
			cpuPkg::PADDSB: result = nibbleSum;
			default: result = sum;
		endcase
	end

	always_comb begin
		flags.z = (result == '0);
		flags.v = overflow;
		flags.n = result[cpuPkg::dataWidth-1];
	end

endmodule

`default_nettype wire

// File: source/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
	input  logic                          clk,
	input  logic                          rst,
	output logic [cpuPkg::dataWidth-1:0]  instrAddr,
	input  logic [cpuPkg::dataWidth-1:0]  instr,
	output logic                          halt,
	output cpuPkg::retireT                retire
);

	cpuPkg::opcodeT op;
	cpuPkg::ctrlT ctrl;
	cpuPkg::flagsT aluFlags;
	logic [cpuPkg::regAddrWidth-1:0] rd;
	logic [cpuPkg::regAddrWidth-1:0] rs;
	logic [cpuPkg::regAddrWidth-1:0] rt;
	logic [cpuPkg::regAddrWidth-1:0] readAddrB;
	logic [cpuPkg::dataWidth-1:0] regA;
	logic [cpuPkg::dataWidth-1:0] regB;
	logic [cpuPkg::dataWidth-1:0] immExt;
	logic [cpuPkg::dataWidth-1:0] aluB;
	logic [cpuPkg::dataWidth-1:0] aluResult;
	logic [cpuPkg::dataWidth-1:0] memData;
	logic [cpuPkg::dataWidth-1:0] loadData;
	logic [cpuPkg::dataWidth-1:0] byteMerged;
	logic [cpuPkg::dataWidth-1:0] wbData;
	logic [cpuPkg::dataWidth-1:0] pc;
	logic [cpuPkg::dataWidth-1:0] pcNext1;
	logic regWe;
	logic memWe;

	// Instruction fields
	assign op = cpuPkg::opcodeT'(instr[15:12]);
	assign rd = instr[11:8];
	assign rs = instr[7:4];
	assign rt = instr[3:0];

	// SW stores rd, LLB and LHB merge into the old rd
	assign readAddrB = (ctrl.memWrite || ctrl.byteLoad) ? rd : rt;

	assign immExt = {{(cpuPkg::dataWidth-4){instr[3]}}, instr[3:0]};
	assign aluB = ctrl.aluSrc ? immExt : regB;

	// Nothing changes once halted
	assign regWe = ctrl.regWrite & ~halt;
	assign memWe = ctrl.memWrite & ~halt;

	assign loadData = ctrl.memRead ? memData : '0;
	// op[0] tells LHB from LLB
	assign byteMerged = op[0] ? {instr[7:0], regB[7:0]} : {regB[15:8], instr[7:0]};

	always_comb begin
		if (ctrl.memToReg)
			wbData = loadData;
		else if (ctrl.byteLoad)
			wbData = byteMerged;
		else if (ctrl.pcSel == cpuPkg::SEL_PCS)
			wbData = pcNext1;
		else
			wbData = aluResult;
	end

	mainControl u_control (.op(op), .ctrl(ctrl));

	registerFile u_regFile (
		.clk(clk), .rst(rst),
		.readAddrA(rs), .readAddrB(readAddrB),
		.writeAddr(rd), .writeEn(regWe), .writeData(wbData),
		.readDataA(regA), .readDataB(regB)
	);

	alu u_alu (.op(op), .a(regA), .b(aluB), .result(aluResult), .flags(aluFlags));

	pcUnit u_pc (
		.clk(clk), .rst(rst), .ctrl(ctrl), .aluFlags(aluFlags),
		.cond(cpuPkg::condT'(instr[11:9])), .offset(instr[8:0]), .target(regA),
		.pc(pc), .pcNext1(pcNext1), .halt(halt)
	);

	dataMemory u_dmem (
		.clk(clk), .addr(aluResult[cpuPkg::dmemAddrWidth-1:0]),
		.writeEn(memWe), .writeData(regB), .readData(memData)
	);

	assign instrAddr = pc;

	// Retire record, unused fields read zero
	always_comb begin
		retire.pc = pc;
		retire.regWe = regWe;
		retire.regAddr = regWe ? rd : '0;
		retire.regData = regWe ? wbData : '0;
		retire.memWe = memWe;
		retire.memAddr = memWe ? aluResult[cpuPkg::dmemAddrWidth-1:0] : '0;
		retire.memData = memWe ? regB : '0;
	end

endmodule

`default_nettype wire

// File: source/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Core sizes
	localparam int dataWidth = 16;
	localparam int regCount = 16;
	localparam int dmemDepth = 256;
	localparam int regAddrWidth = $clog2(regCount);
	localparam int dmemAddrWidth = $clog2(dmemDepth);

	// Instruction opcodes, bits 15 to 12
	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		XOR = 4'd2,
		RED = 4'd3,
		SLL = 4'd4,
		SRA = 4'd5,
		ROR = 4'd6,
		PADDSB = 4'd7,
		LW = 4'd8,
		SW = 4'd9,
		LLB = 4'd10,
		LHB = 4'd11,
		B = 4'd12,
		BR = 4'd13,
		PCS = 4'd14,
		HLT = 4'd15
	} opcodeT;

	// Branch conditions, bits 11 to 9
	typedef enum logic [2:0] {
		NE = 3'd0,
		EQ = 3'd1,
		GT = 3'd2,
		LT = 3'd3,
		GE = 3'd4,
		LE = 3'd5,
		OVF = 3'd6,
		ALWAYS = 3'd7
	} condT;

	// Next PC source
	typedef enum logic [1:0] {
		SEL_SEQ = 2'd0,
		SEL_PCS = 2'd1,
		SEL_HALT = 2'd3
	} pcSelT;

	typedef struct packed {
		logic branch;
		logic regBranch;
		logic byteLoad;
		logic memRead;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic regWrite;
		// Z, V, N from msb down
		logic [2:0] flagWrite;
		pcSelT pcSel;
	} ctrlT;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flagsT;

	// One completed instruction
	typedef struct packed {
		logic [dataWidth-1:0] pc;
		logic regWe;
		logic [regAddrWidth-1:0] regAddr;
		logic [dataWidth-1:0] regData;
		logic memWe;
		logic [dmemAddrWidth-1:0] memAddr;
		logic [dataWidth-1:0] memData;
	} retireT;

endpackage

`default_nettype wire

// File: source/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory (
	input  logic                               clk,
	input  logic [cpuPkg::dmemAddrWidth-1:0]   addr,
	input  logic                               writeEn,
	input  logic [cpuPkg::dataWidth-1:0]       writeData,
	output logic [cpuPkg::dataWidth-1:0]       readData
);

	logic [cpuPkg::dataWidth-1:0] mem [cpuPkg::dmemDepth];

	// Power-up contents
	initial begin
		for (int i = 0; i < cpuPkg::dmemDepth; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (writeEn)
			mem[addr] <= writeData;
	end

	assign readData = mem[addr];

endmodule

`default_nettype wire

// File: source/mainControl.sv
`timescale 1ns/1ps
`default_nettype none

module mainControl (
	input  cpuPkg::opcodeT op,
	output cpuPkg::ctrlT   ctrl
);

	always_comb begin
		// Everything off unless the opcode asks for it
		ctrl = '0;
		ctrl.pcSel = cpuPkg::SEL_SEQ;

		case (op)
			// Register-register ALU ops
			cpuPkg::ADD, cpuPkg::SUB, cpuPkg::XOR, cpuPkg::RED, cpuPkg::PADDSB: begin
				ctrl.regWrite = 1'b1;
			end

			// Shifts take the 4-bit immediate
			cpuPkg::SLL, cpuPkg::SRA, cpuPkg::ROR: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end

			cpuPkg::LW: begin
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end

			cpuPkg::SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end

			// Byte merge into the destination
			cpuPkg::LLB, cpuPkg::LHB: begin
				ctrl.byteLoad = 1'b1;
				ctrl.regWrite = 1'b1;
			end

			cpuPkg::B: begin
				ctrl.branch = 1'b1;
				ctrl.aluSrc = 1'b1;
			end

			// Target comes from a register
			cpuPkg::BR: begin
				ctrl.branch = 1'b1;
				ctrl.regBranch = 1'b1;
			end

			cpuPkg::PCS: begin
				ctrl.regWrite = 1'b1;
				ctrl.pcSel = cpuPkg::SEL_PCS;
			end

			cpuPkg::HLT: begin
				ctrl.pcSel = cpuPkg::SEL_HALT;
			end
		endcase

		// Z for ALU ops except RED and PADDSB
		ctrl.flagWrite[2] = ~op[3] & (op[1:0] != 2'b11);
		// V and N only for ADD and SUB
		ctrl.flagWrite[1:0] = (op[3:1] == 3'b000) ? 2'b11 : 2'b00;
	end

endmodule

`default_nettype wire

// File: source/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
	input  logic                          clk,
	input  logic                          rst,
	input  cpuPkg::ctrlT                  ctrl,
	input  cpuPkg::flagsT                 aluFlags,
	input  cpuPkg::condT                  cond,
	input  logic [8:0]                    offset,
	input  logic [cpuPkg::dataWidth-1:0]  target,
	output logic [cpuPkg::dataWidth-1:0]  pc,
	output logic [cpuPkg::dataWidth-1:0]  pcNext1,
	output logic                          halt
);

	cpuPkg::flagsT flagReg;
	logic condMet;
	logic [cpuPkg::dataWidth-1:0] branchTarget;
	logic [cpuPkg::dataWidth-1:0] nextPc;

	assign pcNext1 = pc + 1'b1;
	assign branchTarget = pcNext1 + {{(cpuPkg::dataWidth-9){offset[8]}}, offset};

	// Tested against flags left by earlier instructions
	always_comb begin
		case (cond)
			cpuPkg::NE: condMet = ~flagReg.z;
			cpuPkg::EQ: condMet = flagReg.z;
			cpuPkg::GT: condMet = ~flagReg.z & ~flagReg.n;
			cpuPkg::LT: condMet = flagReg.n;
			cpuPkg::GE: condMet = flagReg.z | ~flagReg.n;
			cpuPkg::LE: condMet = flagReg.n | flagReg.z;
			cpuPkg::OVF: condMet = flagReg.v;
			default: condMet = 1'b1;
		endcase
	end

	always_comb begin
		nextPc = pcNext1;
		if (ctrl.pcSel == cpuPkg::SEL_HALT) begin
			nextPc = pc;
		end else if (ctrl.branch && condMet) begin
			nextPc = ctrl.regBranch ? target : branchTarget;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			flagReg <= '0;
			halt <= 1'b0;
		end else if (!halt) begin
			pc <= nextPc;
			halt <= (ctrl.pcSel == cpuPkg::SEL_HALT);
			if (ctrl.flagWrite[2])
				flagReg.z <= aluFlags.z;
			if (ctrl.flagWrite[1])
				flagReg.v <= aluFlags.v;
			if (ctrl.flagWrite[0])
				flagReg.n <= aluFlags.n;
		end
	end

endmodule

`default_nettype wire

// File: source/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic [cpuPkg::regAddrWidth-1:0]      readAddrA,
	input  logic [cpuPkg::regAddrWidth-1:0]      readAddrB,
	input  logic [cpuPkg::regAddrWidth-1:0]      writeAddr,
	input  logic                                 writeEn,
	input  logic [cpuPkg::dataWidth-1:0]         writeData,
	output logic [cpuPkg::dataWidth-1:0]         readDataA,
	output logic [cpuPkg::dataWidth-1:0]         readDataB
);

	logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpuPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAddr != '0)) begin
			// r0 is hardwired, writes to it vanish
			regs[writeAddr] <= writeData;
		end
	end

	// Asynchronous reads
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire
